/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= apple_memory_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
logic/a2_pkg.sv
logic/a2bus_if.sv
logic/sdpram32.sv
logic/soft_switch_regs.sv
logic/video_shadow_mem.sv
logic/apple_memory.sv
verification/apple_memory_tb.sv

/* logic/a2_pkg.sv */
// Shared types, register addresses and helpers for the Apple II bus snooper.
// Import by wildcard in the module header of any block that needs them.
`default_nettype none

package a2_pkg;

    // Captured soft switch, colour, mode and keyboard state
    typedef struct packed {
        logic       text_mode;
        logic       mixed_mode;
        logic       page2;
        logic       hires_mode;
        logic       an0;
        logic       an1;
        logic       an2;
        logic       an3;
        logic       store80;
        logic       ramrd;
        logic       ramwrt;
        logic       cxrom;
        logic       altzp;
        logic       c3rom;
        logic       col80;
        logic       altchar;
        logic [3:0] text_color;
        logic [3:0] background_color;
        logic [3:0] border_color;
        logic       monochrome_mode;
        logic       monochrome_dhires_mode;
        logic       linearize_mode;
        logic       shrg_mode;
        logic [7:0] keycode;
        logic       keypress_strobe;
    } a2_mem_state_t;

    // Upper address nibbles of the two soft switch blocks
    localparam logic [11:0] A2_SW_II_BASE  = 12'hC05;
    localparam logic [11:0] A2_SW_IIE_BASE = 12'hC00;

    localparam logic [15:0] A2_ADDR_TEXT_COLOR = 16'hC022;
    localparam logic [15:0] A2_ADDR_BORDER     = 16'hC034;
    localparam logic [15:0] A2_ADDR_MONO       = 16'hC021;
    localparam logic [15:0] A2_ADDR_NEWVIDEO   = 16'hC029;
    localparam logic [15:0] A2_ADDR_KBD        = 16'hC000;
    localparam logic [15:0] A2_ADDR_KBDSTRB    = 16'hC010;

    // Alternate bytes of b and a, upper or lower half picked by sel
    function automatic logic [31:0] interleave_mux(input logic sel,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
        logic [31:0] result;
        if (sel) begin
            result = {b[31:24], a[31:24], b[23:16], a[23:16]};
        end else begin
            result = {b[15:8], a[15:8], b[7:0], a[7:0]};
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* logic/a2bus_if.sv */
// Sampled Apple II bus as seen by the snooping card, with the logic clock.
// The testbench drives it through master; RTL blocks listen through slave.
`timescale 1ns/100ps
`default_nettype none

interface a2bus_if;

    logic        clk_logic;
    logic [15:0] addr;
    logic [7:0]  data;
    logic        rw_n;
    logic        data_in_strobe;
    logic        phi1_posedge;
    logic        m2sel_n;
    // Card-side aux bank hint
    logic        m2b0;

    modport master (
        output clk_logic, addr, data, rw_n, data_in_strobe,
        output phi1_posedge, m2sel_n, m2b0
    );

    modport slave (
        input clk_logic, addr, data, rw_n, data_in_strobe,
        input phi1_posedge, m2sel_n, m2b0
    );

endinterface

`default_nettype wire

/* logic/apple_memory.sv */
// Top of the Apple II shadow memory: soft switch capture feeding the
// video shadow RAMs. VGC_MEMORY selects the 32 KB aux bank for the VGC.
`timescale 1ns/100ps
`default_nettype none

module apple_memory
    import a2_pkg::*;
#(
    parameter int VGC_MEMORY = 0
) (
    a2bus_if.slave              bus,
    input  wire logic           arst_n_i,
    input  wire logic [15:0]    video_address_i,
    input  wire logic           vgc_active_i,
    input  wire logic [12:0]    vgc_address_i,
    output logic      [31:0]    video_data_o,
    output logic      [31:0]    vgc_data_o,
    output a2_mem_state_t       mem_state_o
);

    a2_mem_state_t mem_state;

    soft_switch_regs u_switch_regs (
        .bus      (bus),
        .arst_n_i (arst_n_i),
        .state_o  (mem_state)
    );

    video_shadow_mem #(
        .VGC_MEMORY (VGC_MEMORY)
    ) u_shadow_mem (
        .bus             (bus),
        .arst_n_i        (arst_n_i),
        .state_i         (mem_state),
        .video_address_i (video_address_i),
        .vgc_active_i    (vgc_active_i),
        .vgc_address_i   (vgc_address_i),
        .video_data_o    (video_data_o),
        .vgc_data_o      (vgc_data_o)
    );

    assign mem_state_o = mem_state;

endmodule

`default_nettype wire

/* logic/sdpram32.sv */
// Simple dual-port block RAM of 32-bit words with per-byte write enables.
// Read data is registered, so it follows the read address by one clock.
`timescale 1ns/100ps
`default_nettype none

module sdpram32 #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic                  clk_i,
    input  wire logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  wire logic [31:0]           wr_data_i,
    input  wire logic                  wr_en_i,
    input  wire logic [3:0]            byte_en_i,
    input  wire logic [ADDR_WIDTH-1:0] rd_addr_i,
    output logic      [31:0]           rd_data_o
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [31:0] mem [0:DEPTH-1];

    // Power-up contents are all zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'h0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en_i[b]) begin
                    mem[wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // Old data on a same-address collision
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

/* logic/soft_switch_regs.sv */
// Snoops soft switch, colour, video mode and keyboard accesses on the bus
// and holds the resulting machine state for the shadow memory and display.
`timescale 1ns/100ps
`default_nettype none

module soft_switch_regs
    import a2_pkg::*;
(
    a2bus_if.slave             bus,
    input  wire logic          arst_n_i,
    output a2_mem_state_t      state_o
);

    logic       write_strobe;
    logic       read_strobe;
    logic       sw_access;
    logic [7:0] sw_ii;
    logic [7:0] sw_iie;
    logic [3:0] text_color;
    logic [3:0] background_color;
    logic [3:0] border_color;
    logic       mono;
    logic       mono_dhires;
    logic       linearize;
    logic       shrg;
    logic [7:0] keycode;
    logic       key_strobe;

    assign write_strobe = !bus.rw_n && bus.data_in_strobe;
    assign read_strobe  = bus.rw_n && bus.data_in_strobe;
    assign sw_access    = bus.phi1_posedge && !bus.m2sel_n;

    // II display switches toggle on any access, IIe ones on writes only
    always_ff @(posedge bus.clk_logic or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sw_ii  <= 8'b1000_0011;
            sw_iie <= 8'h00;
        end else begin
            if (sw_access && bus.addr[15:4] == A2_SW_II_BASE) begin
                sw_ii[bus.addr[3:1]] <= bus.addr[0];
            end
            if (sw_access && !bus.rw_n && bus.addr[15:4] == A2_SW_IIE_BASE) begin
                sw_iie[bus.addr[3:1]] <= bus.addr[0];
            end
        end
    end

    // IIgs style colour and video mode registers
    always_ff @(posedge bus.clk_logic or negedge arst_n_i) begin
        if (!arst_n_i) begin
            text_color       <= 4'hF;
            background_color <= 4'h0;
            border_color     <= 4'h0;
            mono             <= 1'b0;
            mono_dhires      <= 1'b0;
            linearize        <= 1'b0;
            shrg             <= 1'b0;
        end else if (write_strobe) begin
            case (bus.addr)
                A2_ADDR_TEXT_COLOR: begin
                    text_color       <= bus.data[7:4];
                    background_color <= bus.data[3:0];
                end
                A2_ADDR_BORDER: border_color <= bus.data[3:0];
                A2_ADDR_MONO: mono <= bus.data[7];
                A2_ADDR_NEWVIDEO: begin
                    mono_dhires <= bus.data[5];
                    linearize   <= bus.data[6] | bus.data[7];
                    shrg        <= bus.data[7];
                end
                default: ;
            endcase
        end
    end

    // Keyboard latch, a new key only once the previous one is cleared
    always_ff @(posedge bus.clk_logic or negedge arst_n_i) begin
        if (!arst_n_i) begin
            keycode    <= 8'h00;
            key_strobe <= 1'b0;
        end else begin
            key_strobe <= 1'b0;
            if (read_strobe && bus.addr == A2_ADDR_KBD) begin
                if (bus.data[7] && !keycode[7]) begin
                    keycode    <= bus.data;
                    key_strobe <= 1'b1;
                end
            end else if (bus.data_in_strobe && bus.addr == A2_ADDR_KBDSTRB) begin
                keycode[7] <= 1'b0;
            end
        end
    end

    always_comb begin
        state_o.text_mode              = sw_ii[0];
        state_o.mixed_mode             = sw_ii[1];
        state_o.page2                  = sw_ii[2];
        state_o.hires_mode             = sw_ii[3];
        state_o.an0                    = sw_ii[4];
        state_o.an1                    = sw_ii[5];
        state_o.an2                    = sw_ii[6];
        state_o.an3                    = sw_ii[7];
        state_o.store80                = sw_iie[0];
        state_o.ramrd                  = sw_iie[1];
        state_o.ramwrt                 = sw_iie[2];
        state_o.cxrom                  = sw_iie[3];
        state_o.altzp                  = sw_iie[4];
        state_o.c3rom                  = sw_iie[5];
        state_o.col80                  = sw_iie[6];
        state_o.altchar                = sw_iie[7];
        state_o.text_color             = text_color;
        state_o.background_color       = background_color;
        state_o.border_color           = border_color;
        state_o.monochrome_mode        = mono;
        state_o.monochrome_dhires_mode = mono_dhires;
        state_o.linearize_mode         = linearize;
        state_o.shrg_mode              = shrg;
        state_o.keycode                = keycode;
        state_o.keypress_strobe        = key_strobe;
    end

    // The latched bit 7 must block a second pulse
    a_key_strobe_single: assert property (
        @(posedge bus.clk_logic) disable iff (!arst_n_i)
        key_strobe |=> !key_strobe
    );

endmodule

`default_nettype wire

/* logic/video_shadow_mem.sv */
// Mirrors bus writes to text and hires pages into block RAM, picking the
// main or aux bank, and serves the video scanner and VGC read ports.
`timescale 1ns/100ps
`default_nettype none

module video_shadow_mem
    import a2_pkg::*;
#(
    parameter int VGC_MEMORY = 0
) (
    a2bus_if.slave              bus,
    input  wire logic           arst_n_i,
    input  wire a2_mem_state_t  state_i,
    input  wire logic [15:0]    video_address_i,
    input  wire logic           vgc_active_i,
    input  wire logic [12:0]    vgc_address_i,
    output logic      [31:0]    video_data_o,
    output logic      [31:0]    vgc_data_o
);

    logic        write_strobe;
    logic        aux_sel;
    logic        e1;
    logic        bus_text;
    logic        bus_hires_lo;
    logic        bus_hires_hi;
    logic [11:0] text_wr_off;
    logic [1:0]  hires_page;
    logic [14:0] hires_wr_off;
    logic [3:0]  hires_be;
    logic [31:0] wr_word;

    logic        text_we;
    logic        main_we;
    logic        aux_lo_we;
    logic        aux_hi_we;
    logic [11:0] aux_lo_addr;
    logic [11:0] aux_hi_addr;
    logic [3:0]  aux_lo_be;
    logic [3:0]  aux_hi_be;

    logic        video_text;
    logic        video_hires;
    logic [9:0]  text_rd_addr;
    logic [11:0] main_rd_addr;
    logic [11:0] aux_rd_addr;
    logic [31:0] text_data;
    logic [31:0] main_data;
    logic [31:0] aux_lo_data;
    logic [31:0] aux_hi_data;

    // Read selects registered alongside the RAM read
    logic        text_sel_q;
    logic        hires_sel_q;
    logic        video_lane_q;
    logic        vgc_active_q;
    logic        vgc_lane_q;

    assign write_strobe = !bus.rw_n && bus.data_in_strobe;

    // IIe bank rules per page group
    always_comb begin
        if (bus.addr[15:9] == 7'h00 || bus.addr[15:14] == 2'b11) begin
            aux_sel = state_i.altzp;
        end else if (bus.addr[15:10] == 6'b000001) begin
            aux_sel = state_i.store80 ? state_i.page2 : (state_i.ramwrt && !bus.rw_n);
        end else if (bus.addr[15:13] == 3'b001) begin
            aux_sel = (state_i.store80 && state_i.hires_mode) ? state_i.page2
                                                              : (state_i.ramwrt && !bus.rw_n);
        end else begin
            aux_sel = state_i.ramwrt && !bus.rw_n;
        end
    end

    assign e1 = aux_sel || bus.m2b0;

    assign bus_text     = bus.addr[15:10] inside {6'd1, 6'd2};
    assign bus_hires_lo = bus.addr[15:13] inside {3'd1, 3'd2};
    assign bus_hires_hi = bus.addr[15:13] inside {3'd3, 3'd4};

    // Main and aux text bytes share one word, bank in the lowest bit
    assign text_wr_off  = {!bus.addr[10], bus.addr[9:0], e1};
    assign hires_page   = bus.addr[14:13] - 2'd1;
    assign hires_wr_off = {hires_page, bus.addr[12:0]};
    assign hires_be     = 4'b0001 << hires_wr_off[1:0];
    assign wr_word      = {4{bus.data}};

    assign text_we = write_strobe && bus_text;
    assign main_we = write_strobe && bus_hires_lo && !e1;

    always_comb begin
        aux_lo_we   = 1'b0;
        aux_hi_we   = 1'b0;
        aux_lo_addr = hires_wr_off[13:2];
        aux_hi_addr = hires_wr_off[13:2];
        aux_lo_be   = hires_be;
        aux_hi_be   = hires_be;
        if (VGC_MEMORY != 0 && state_i.linearize_mode) begin
            // Even bytes low, odd bytes high, both at half offset
            aux_lo_we   = write_strobe && (bus_hires_lo || bus_hires_hi) && e1;
            aux_hi_we   = aux_lo_we;
            aux_lo_addr = hires_wr_off[14:3];
            aux_hi_addr = hires_wr_off[14:3];
            aux_lo_be   = hires_wr_off[0] ? 4'b0000 : 4'b0001 << hires_wr_off[2:1];
            aux_hi_be   = hires_wr_off[0] ? 4'b0001 << hires_wr_off[2:1] : 4'b0000;
        end else begin
            aux_lo_we = write_strobe && bus_hires_lo && e1;
            aux_hi_we = (VGC_MEMORY != 0) && write_strobe && bus_hires_hi && e1;
        end
    end

    assign video_text   = video_address_i[15:10] inside {6'd1, 6'd2};
    assign video_hires  = video_address_i[15:13] inside {3'd1, 3'd2};
    assign text_rd_addr = {!video_address_i[10], video_address_i[9:1]};
    assign main_rd_addr = {!video_address_i[13], video_address_i[12:2]};
    assign aux_rd_addr  = (VGC_MEMORY != 0 && vgc_active_i) ? vgc_address_i[12:1]
                                                            : main_rd_addr;

    sdpram32 #(.ADDR_WIDTH(10)) text_vram (
        .clk_i     (bus.clk_logic),
        .wr_addr_i (text_wr_off[11:2]),
        .wr_data_i (wr_word),
        .wr_en_i   (text_we),
        .byte_en_i (4'b0001 << text_wr_off[1:0]),
        .rd_addr_i (text_rd_addr),
        .rd_data_o (text_data)
    );

    sdpram32 #(.ADDR_WIDTH(12)) hires_main (
        .clk_i     (bus.clk_logic),
        .wr_addr_i (hires_wr_off[13:2]),
        .wr_data_i (wr_word),
        .wr_en_i   (main_we),
        .byte_en_i (hires_be),
        .rd_addr_i (main_rd_addr),
        .rd_data_o (main_data)
    );

    sdpram32 #(.ADDR_WIDTH(12)) hires_aux_lo (
        .clk_i     (bus.clk_logic),
        .wr_addr_i (aux_lo_addr),
        .wr_data_i (wr_word),
        .wr_en_i   (aux_lo_we),
        .byte_en_i (aux_lo_be),
        .rd_addr_i (aux_rd_addr),
        .rd_data_o (aux_lo_data)
    );

    // Second 16 KB of aux only on cards with VGC memory
    generate
        if (VGC_MEMORY != 0) begin : g_vgc
            sdpram32 #(.ADDR_WIDTH(12)) hires_aux_hi (
                .clk_i     (bus.clk_logic),
                .wr_addr_i (aux_hi_addr),
                .wr_data_i (wr_word),
                .wr_en_i   (aux_hi_we),
                .byte_en_i (aux_hi_be),
                .rd_addr_i (aux_rd_addr),
                .rd_data_o (aux_hi_data)
            );
        end else begin : g_no_vgc
            assign aux_hi_data = 32'h0;
        end
    endgenerate

    always_ff @(posedge bus.clk_logic or negedge arst_n_i) begin
        if (!arst_n_i) begin
            text_sel_q   <= 1'b0;
            hires_sel_q  <= 1'b0;
            video_lane_q <= 1'b0;
            vgc_active_q <= 1'b0;
            vgc_lane_q   <= 1'b0;
        end else begin
            text_sel_q   <= video_text;
            hires_sel_q  <= video_hires;
            video_lane_q <= video_address_i[1];
            vgc_active_q <= vgc_active_i;
            vgc_lane_q   <= vgc_address_i[0];
        end
    end

    always_comb begin
        if (vgc_active_q) begin
            video_data_o = 32'h0;
        end else if (text_sel_q) begin
            video_data_o = text_data;
        end else if (hires_sel_q) begin
            video_data_o = interleave_mux(video_lane_q, main_data, aux_lo_data);
        end else begin
            video_data_o = 32'h0;
        end
    end

    assign vgc_data_o = vgc_active_q ? interleave_mux(vgc_lane_q, aux_lo_data, aux_hi_data)
                                     : 32'h0;

    // Only bus writes into the shadowed address window reach a RAM
    a_we_only_on_write: assert property (
        @(posedge bus.clk_logic) disable iff (!arst_n_i)
        (text_we || main_we || aux_lo_we || aux_hi_we)
            |-> (!bus.rw_n && bus.data_in_strobe
                 && bus.addr >= 16'h0400 && bus.addr <= 16'h9FFF)
    );

endmodule

`default_nettype wire

/* verification/apple_memory_tb.sv */
// Table-driven testbench for the Apple II shadow memory top level.
// Builds stimulus and expected values from a software model, then replays them.
`timescale 1ns/100ps
`default_nettype none

module apple_memory_tb
    import a2_pkg::*;
;

    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_SW_RD = 2;
    localparam int OP_SW_WR = 3;
    localparam int OP_KBD   = 4;
    localparam int OP_STATE = 5;
    localparam int OP_VIDEO = 6;
    localparam int OP_VGC   = 7;
    localparam int MAX_ENTRIES  = 512;
    localparam int READ_LATENCY = 1;

    logic          arst_n;
    logic [15:0]   video_address;
    logic          vgc_active;
    logic [12:0]   vgc_address;
    logic [31:0]   video_data;
    logic [31:0]   vgc_data;
    a2_mem_state_t mem_state;
    integer        seed;

    // Stimulus table
    int          tab_op   [0:MAX_ENTRIES-1];
    logic [15:0] tab_addr [0:MAX_ENTRIES-1];
    logic [7:0]  tab_data [0:MAX_ENTRIES-1];
    logic [63:0] tab_exp  [0:MAX_ENTRIES-1];
    int          tab_count;

    // Reference model
    logic [7:0] m_ii;
    logic [7:0] m_iie;
    logic [3:0] m_text;
    logic [3:0] m_bg;
    logic [3:0] m_border;
    logic       m_mono;
    logic       m_mdh;
    logic       m_lin;
    logic       m_shr;
    logic [7:0] m_kc;
    logic [7:0] main_mem [0:65535];
    logic [7:0] aux_mem  [0:65535];
    logic [7:0] lin_mem  [0:32767];
    logic [15:0] addr_q [$];

    a2bus_if bus_if ();

    apple_memory #(.VGC_MEMORY(1)) UUT (
        .bus             (bus_if),
        .arst_n_i        (arst_n),
        .video_address_i (video_address),
        .vgc_active_i    (vgc_active),
        .vgc_address_i   (vgc_address),
        .video_data_o    (video_data),
        .vgc_data_o      (vgc_data),
        .mem_state_o     (mem_state)
    );

    initial bus_if.clk_logic = 1'b0;
    always #5 bus_if.clk_logic = ~bus_if.clk_logic;

    // Overall watchdog
    initial begin
        #2000000;
        $display("Simulation timed out before the table finished");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic model_aux_bank(input logic [15:0] a);
        logic store80;
        logic ramwrt;
        store80 = m_iie[0];
        ramwrt  = m_iie[2];
        if (a >= 16'h0400 && a <= 16'h07FF) begin
            return store80 ? m_ii[2] : ramwrt;
        end else if (a >= 16'h2000 && a <= 16'h3FFF) begin
            return (store80 && m_ii[3]) ? m_ii[2] : ramwrt;
        end
        return ramwrt;
    endfunction

    function automatic a2_mem_state_t model_state();
        a2_mem_state_t s;
        {s.an3, s.an2, s.an1, s.an0} = m_ii[7:4];
        {s.hires_mode, s.page2, s.mixed_mode, s.text_mode} = m_ii[3:0];
        {s.altchar, s.col80, s.c3rom, s.altzp} = m_iie[7:4];
        {s.cxrom, s.ramwrt, s.ramrd, s.store80} = m_iie[3:0];
        s.text_color             = m_text;
        s.background_color       = m_bg;
        s.border_color           = m_border;
        s.monochrome_mode        = m_mono;
        s.monochrome_dhires_mode = m_mdh;
        s.linearize_mode         = m_lin;
        s.shrg_mode              = m_shr;
        s.keycode                = m_kc;
        s.keypress_strobe        = 1'b0;
        return s;
    endfunction

    task automatic add_entry(input int op, input logic [15:0] a, input logic [7:0] d,
                             input logic [63:0] e);
        tab_op[tab_count]   = op;
        tab_addr[tab_count] = a;
        tab_data[tab_count] = d;
        tab_exp[tab_count]  = e;
        tab_count++;
    endtask

    task automatic switch_access(input logic [15:0] a, input logic is_write);
        if (a[15:4] == 12'hC05) m_ii[a[3:1]] = a[0];
        if (is_write && a[15:4] == 12'hC00) m_iie[a[3:1]] = a[0];
        add_entry(is_write ? OP_SW_WR : OP_SW_RD, a, 8'h00, 64'h0);
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        logic e1;
        e1 = model_aux_bank(a);
        case (a)
            16'hC022: {m_text, m_bg} = d;
            16'hC034: m_border = d[3:0];
            16'hC021: m_mono = d[7];
            16'hC029: begin
                m_mdh = d[5];
                m_lin = d[6] | d[7];
                m_shr = d[7];
            end
            16'hC010: m_kc[7] = 1'b0;
            default: ;
        endcase
        if (m_lin && e1 && a >= 16'h2000 && a <= 16'h9FFF) begin
            lin_mem[a - 16'h2000] = d;
        end else if ((a >= 16'h0400 && a <= 16'h0BFF) || (a >= 16'h2000 && a <= 16'h5FFF)) begin
            if (e1) aux_mem[a] = d;
            else main_mem[a] = d;
        end
        add_entry(OP_WRITE, a, d, 64'h0);
    endtask

    task automatic key_read(input logic [7:0] d);
        logic pulse;
        pulse = d[7] && !m_kc[7];
        if (pulse) m_kc = d;
        add_entry(OP_KBD, A2_ADDR_KBD, d, {63'h0, pulse});
    endtask

    task automatic video_check(input logic [15:0] va);
        logic [15:0] b;
        b = va & 16'hFFFE;
        add_entry(OP_VIDEO, va, 8'h00,
                  {32'h0, aux_mem[b + 1], main_mem[b + 1], aux_mem[b], main_mem[b]});
    endtask

    task automatic vgc_check(input logic [12:0] v);
        int b;
        b = 4 * v;
        add_entry(OP_VGC, {3'b000, v}, 8'h00,
                  {32'h0, lin_mem[b + 3], lin_mem[b + 2], lin_mem[b + 1], lin_mem[b]});
    endtask

    task automatic state_check();
        logic [63:0] e;
        e = model_state();
        add_entry(OP_STATE, 16'h0, 8'h00, e);
    endtask

    task automatic bus_idle();
        bus_if.addr           = 16'h0000;
        bus_if.data           = 8'h00;
        bus_if.rw_n           = 1'b1;
        bus_if.data_in_strobe = 1'b0;
        bus_if.phi1_posedge   = 1'b0;
        bus_if.m2sel_n        = 1'b1;
        bus_if.m2b0           = 1'b0;
    endtask

    // Read data follows the address by a fixed latency
    task automatic wait_latency();
        int n;
        for (n = 0; n < READ_LATENCY; n++) begin
            @(negedge bus_if.clk_logic);
        end
    endtask

    task automatic run_entry(input int i);
        string name;
        int    pulses;
        int    c;
        name = $sformatf("entry%0d_op%0d_addr%h", i, tab_op[i], tab_addr[i]);
        case (tab_op[i])
            OP_WRITE, OP_READ, OP_SW_RD, OP_SW_WR, OP_KBD: begin
                bus_if.addr           = tab_addr[i];
                bus_if.data           = tab_data[i];
                bus_if.rw_n           = (tab_op[i] == OP_WRITE || tab_op[i] == OP_SW_WR)
                                        ? 1'b0 : 1'b1;
                bus_if.data_in_strobe = 1'b1;
                bus_if.phi1_posedge   = (tab_op[i] == OP_SW_RD || tab_op[i] == OP_SW_WR);
                bus_if.m2sel_n        = !(tab_op[i] == OP_SW_RD || tab_op[i] == OP_SW_WR);
                @(negedge bus_if.clk_logic);
                bus_idle();
                if (tab_op[i] == OP_KBD) begin
                    pulses = 0;
                    for (c = 0; c < 4; c++) begin
                        if (mem_state.keypress_strobe) pulses++;
                        @(negedge bus_if.clk_logic);
                    end
                    check_value(name, tab_exp[i], pulses);
                end
            end
            OP_STATE: check_value(name, tab_exp[i], {23'h0, mem_state});
            OP_VIDEO: begin
                video_address = tab_addr[i];
                vgc_active    = 1'b0;
                wait_latency();
                check_value(name, tab_exp[i], {32'h0, video_data});
            end
            default: begin
                vgc_address   = tab_addr[i][12:0];
                vgc_active    = 1'b1;
                video_address = 16'h2000;
                wait_latency();
                check_value(name, tab_exp[i], {32'h0, vgc_data});
                check_value({name, "_video_blank"}, 64'h0, {32'h0, video_data});
                vgc_active = 1'b0;
            end
        endcase
    endtask

    initial begin
        logic [15:0] a;
        int i;
        seed = 60056;
        tab_count = 0;
        arst_n = 1'b0;
        video_address = 16'h0000;
        vgc_active = 1'b0;
        vgc_address = 13'h0;
        bus_idle();
        m_ii = 8'b1000_0011;
        m_iie = 8'h00;
        {m_text, m_bg, m_border} = 12'hF00;
        {m_mono, m_mdh, m_lin, m_shr} = 4'h0;
        m_kc = 8'h00;
        for (i = 0; i < 65536; i++) begin
            main_mem[i] = 8'h00;
            aux_mem[i]  = 8'h00;
        end
        for (i = 0; i < 32768; i++) lin_mem[i] = 8'h00;

        state_check();
        for (i = 0; i < 16; i++) begin
            switch_access(16'hC050 + i, 1'b0);
            state_check();
        end
        switch_access(16'hC050, 1'b1);
        switch_access(16'hC052, 1'b0);
        switch_access(16'hC054, 1'b1);
        switch_access(16'hC057, 1'b0);
        state_check();
        // IIe switches ignore reads
        for (i = 0; i < 16; i++) switch_access(16'hC000 + i, 1'b0);
        state_check();
        for (i = 1; i < 16; i += 2) switch_access(16'hC000 + i, 1'b1);
        state_check();
        for (i = 0; i < 16; i += 2) switch_access(16'hC000 + i, 1'b1);
        state_check();

        bus_write(A2_ADDR_TEXT_COLOR, $random(seed));
        bus_write(A2_ADDR_BORDER, $random(seed));
        bus_write(A2_ADDR_MONO, 8'h80);
        bus_write(A2_ADDR_NEWVIDEO, 8'h40);
        state_check();
        bus_write(A2_ADDR_NEWVIDEO, 8'h80);
        state_check();
        bus_write(A2_ADDR_NEWVIDEO, 8'h20);
        bus_write(A2_ADDR_MONO, 8'h00);
        state_check();

        key_read(8'h41);
        key_read(8'hC1);
        key_read(8'hC2);
        state_check();
        bus_write(A2_ADDR_KBDSTRB, 8'h00);
        state_check();
        key_read(8'hC3);
        add_entry(OP_READ, A2_ADDR_KBDSTRB, 8'h00, 64'h0);
        m_kc[7] = 1'b0;
        state_check();

        // Text pages, main then aux through store80 and page2
        for (i = 0; i < 16; i++) begin
            a = 16'h0400 + ($random(seed) & 16'h07FF);
            addr_q.push_back(a);
            bus_write(a, $random(seed));
        end
        switch_access(16'hC001, 1'b1);
        switch_access(16'hC055, 1'b0);
        for (i = 0; i < 16; i++) begin
            a = 16'h0400 + ($random(seed) & 16'h07FF);
            addr_q.push_back(a);
            bus_write(a, $random(seed));
        end
        while (addr_q.size() > 0) video_check(addr_q.pop_front());
        switch_access(16'hC054, 1'b0);
        switch_access(16'hC000, 1'b1);

        // Hires pages, main then aux through ramwrt
        for (i = 0; i < 24; i++) begin
            if (i == 12) switch_access(16'hC005, 1'b1);
            a = 16'h2000 + ($random(seed) & 16'h3FFF);
            addr_q.push_back(a);
            bus_write(a, $random(seed));
        end
        while (addr_q.size() > 0) video_check(addr_q.pop_front());

        // Linear aux layout seen through the VGC port
        bus_write(A2_ADDR_NEWVIDEO, 8'h40);
        for (i = 0; i < 64; i++) bus_write(16'h2000 + i, $random(seed));
        for (i = 0; i < 32; i++) bus_write(16'h8000 + i, $random(seed));
        for (i = 0; i < 16; i++) vgc_check(i);
        for (i = 0; i < 8; i++) vgc_check(13'h1800 + i);
        state_check();

        repeat (8) @(negedge bus_if.clk_logic);
        arst_n = 1'b1;
        @(negedge bus_if.clk_logic);
        for (i = 0; i < tab_count; i++) run_entry(i);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
